/* src/proxy_test_pkg.sv */
`default_nettype none

package proxy_test_pkg;

    // ------------------------------------------------
    // APB bus
    // ------------------------------------------------
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    // Region select in paddr[11:8]
    localparam logic [3:0] REGION_INFO = 4'h0;
    localparam logic [3:0] REGION_MEM  = 4'h1;

    // Register proxy map
    localparam logic [7:0] OFS_PRE     = 8'h00;
    localparam logic [7:0] OFS_POST    = 8'h04;
    localparam logic [7:0] OFS_TRIGGER = 8'h08;
    localparam logic [7:0] OFS_STATUS  = 8'h0C;

    // Memory proxy map
    localparam logic [7:0] OFS_ADDR       = 8'h00;
    localparam logic [7:0] OFS_WR_DATA    = 8'h04;
    localparam logic [7:0] OFS_CMD        = 8'h08;
    localparam logic [7:0] OFS_MEM_STATUS = 8'h0C;
    localparam logic [7:0] OFS_RD_DATA    = 8'h10;

    // ASCII " PRE" and "POST"
    localparam logic [31:0] INFO_PRE  = 32'h2050_5245;
    localparam logic [31:0] INFO_POST = 32'h504F_5354;

    // ------------------------------------------------
    // Memory proxy command path
    // ------------------------------------------------
    localparam int MEM_ADDR_W = 16;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2,
        OP_CLEAR = 2'd3
    } mem_op_e;

    typedef struct packed {
        logic                  valid;
        mem_op_e               op;
        logic [MEM_ADDR_W-1:0] addr;
        logic [31:0]           data;
    } mem_cmd_t;

    typedef struct packed {
        logic        busy;
        logic        rd_done;
        logic [31:0] rd_data;
    } mem_sts_t;

endpackage

`default_nettype wire

/* src/mem_ram_sp.sv */
`default_nettype none

module mem_ram_sp #(
    parameter int MEM_DEPTH = 1024
) (
    input  wire logic                                 clk,
    input  wire logic                                 i_en,
    input  wire logic                                 i_wr,
    input  wire logic [proxy_test_pkg::MEM_ADDR_W-1:0] i_addr,
    input  wire logic [31:0]                          i_wdata,
    output logic      [31:0]                          o_rdata
);
    localparam int AW = $clog2(MEM_DEPTH);

    logic [31:0] mem [MEM_DEPTH];

    // Upper address bits beyond the depth are ignored
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_wr) begin
                mem[i_addr[AW-1:0]] <= i_wdata;
            end else begin
                o_rdata <= mem[i_addr[AW-1:0]];
            end
        end
    end

endmodule

`default_nettype wire

/* src/mem_proxy_engine.sv */
`default_nettype none

module mem_proxy_engine #(
    parameter int MEM_DEPTH = 1024
) (
    input  wire logic                                 clk,
    input  wire logic                                 srst,
    input  wire proxy_test_pkg::mem_cmd_t              i_cmd,
    output proxy_test_pkg::mem_sts_t                  o_sts,
    output logic                                      o_ram_en,
    output logic                                      o_ram_wr,
    output logic [proxy_test_pkg::MEM_ADDR_W-1:0]     o_ram_addr,
    output logic [31:0]                               o_ram_wdata,
    input  wire logic [31:0]                          i_ram_rdata
);
    localparam int AW = $clog2(MEM_DEPTH);

    typedef logic [proxy_test_pkg::MEM_ADDR_W-1:0] ram_addr_t;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_READ_WAIT
    } state_e;

    state_e        state;
    logic [AW-1:0] clr_cnt;
    logic [AW-1:0] cmd_addr;
    logic [31:0]   cmd_data;

    // ------------------------------------------------
    // FSM
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state   <= ST_INIT;
            clr_cnt <= '0;
        end else begin
            case (state)
                ST_INIT: begin
                    clr_cnt <= clr_cnt + 1'b1;
                    // Depth is a power of two, so all ones is the last word
                    if (&clr_cnt) state <= ST_IDLE;
                end
                ST_IDLE: begin
                    if (i_cmd.valid) begin
                        case (i_cmd.op)
                            proxy_test_pkg::OP_WRITE: state <= ST_WRITE;
                            proxy_test_pkg::OP_READ:  state <= ST_READ;
                            proxy_test_pkg::OP_CLEAR: begin
                                state   <= ST_INIT;
                                clr_cnt <= '0;
                            end
                            default: state <= ST_IDLE;
                        endcase
                    end
                end
                ST_WRITE:     state <= ST_IDLE;
                ST_READ:      state <= ST_READ_WAIT;
                ST_READ_WAIT: state <= ST_IDLE;
                default:      state <= ST_IDLE;
            endcase
        end
    end

    // Command payload
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_cmd.valid) begin
            cmd_addr <= i_cmd.addr[AW-1:0];
            cmd_data <= i_cmd.data;
        end
    end

    // RAM port
    assign o_ram_en    = (state == ST_INIT) || (state == ST_WRITE) || (state == ST_READ);
    assign o_ram_wr    = (state == ST_INIT) || (state == ST_WRITE);
    assign o_ram_addr  = ram_addr_t'((state == ST_INIT) ? clr_cnt : cmd_addr);
    assign o_ram_wdata = (state == ST_INIT) ? 32'h0 : cmd_data;

    // Read data is on the RAM output in the wait state
    assign o_sts = '{busy: (state != ST_IDLE), rd_done: (state == ST_READ_WAIT),
                     rd_data: i_ram_rdata};

endmodule

`default_nettype wire

/* src/mem_proxy_regs.sv */
`default_nettype none

module mem_proxy_regs (
    input  wire logic                    clk,
    input  wire logic                    srst,
    input  wire proxy_test_pkg::apb_req_t i_apb,
    output proxy_test_pkg::apb_rsp_t     o_apb,
    output proxy_test_pkg::mem_cmd_t     o_cmd,
    input  wire proxy_test_pkg::mem_sts_t i_sts
);
    localparam int AW = proxy_test_pkg::MEM_ADDR_W;

    logic                    setup;
    logic                    access;
    logic                    busy_now;
    logic [31:0]             rd_word;
    logic                    err;
    logic                    pready_q;
    logic                    pslverr_q;
    logic [31:0]             prdata_q;
    logic [AW-1:0]           addr_q;
    logic [31:0]             wr_data_q;
    logic [31:0]             rd_data_q;
    logic                    cmd_valid_q;
    proxy_test_pkg::mem_op_e cmd_op_q;

    assign setup  = i_apb.psel & ~i_apb.penable;
    assign access = i_apb.psel & i_apb.penable;

    // A command still in flight to the engine counts as busy
    assign busy_now = i_sts.busy | cmd_valid_q;

    always_comb begin
        rd_word = 32'h0;
        err     = 1'b0;
        case (i_apb.paddr[7:0])
            proxy_test_pkg::OFS_ADDR:    rd_word = 32'(addr_q);
            proxy_test_pkg::OFS_WR_DATA: rd_word = wr_data_q;
            proxy_test_pkg::OFS_CMD:     err = i_apb.pwrite & busy_now;
            proxy_test_pkg::OFS_MEM_STATUS: begin
                rd_word = {31'h0, busy_now};
                err     = i_apb.pwrite;
            end
            proxy_test_pkg::OFS_RD_DATA: begin
                rd_word = rd_data_q;
                err     = i_apb.pwrite;
            end
            default: err = 1'b1;
        endcase
    end

    // ------------------------------------------------
    // Register writes and command issue
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            pready_q    <= 1'b0;
            pslverr_q   <= 1'b0;
            addr_q      <= '0;
            wr_data_q   <= 32'h0;
            rd_data_q   <= 32'h0;
            cmd_valid_q <= 1'b0;
            cmd_op_q    <= proxy_test_pkg::OP_NOP;
        end else begin
            pready_q    <= setup;
            pslverr_q   <= setup & err;
            cmd_valid_q <= 1'b0;
            if (access && i_apb.pwrite && !pslverr_q) begin
                case (i_apb.paddr[7:0])
                    proxy_test_pkg::OFS_ADDR:    addr_q <= i_apb.pwdata[AW-1:0];
                    proxy_test_pkg::OFS_WR_DATA: wr_data_q <= i_apb.pwdata;
                    proxy_test_pkg::OFS_CMD: begin
                        // NOP is accepted and dropped
                        cmd_op_q    <= proxy_test_pkg::mem_op_e'(i_apb.pwdata[1:0]);
                        cmd_valid_q <= (i_apb.pwdata[1:0] != proxy_test_pkg::OP_NOP);
                    end
                    default: ;
                endcase
            end
            if (i_sts.rd_done) begin
                rd_data_q <= i_sts.rd_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (setup) begin
            prdata_q <= rd_word;
        end
    end

    assign o_apb = '{pready: pready_q, prdata: prdata_q, pslverr: pslverr_q};
    assign o_cmd = '{valid: cmd_valid_q, op: cmd_op_q, addr: addr_q, data: wr_data_q};

endmodule

`default_nettype wire

/* src/proxy_info_regs.sv */
`default_nettype none

module proxy_info_regs (
    input  wire logic                    clk,
    input  wire logic                    srst,
    input  wire proxy_test_pkg::apb_req_t i_apb,
    output proxy_test_pkg::apb_rsp_t     o_apb
);
    logic        setup;
    logic        access;
    logic [31:0] rd_word;
    logic        err;
    logic        pready_q;
    logic        pslverr_q;
    logic [31:0] prdata_q;
    logic [31:0] trigger_q;
    logic [31:0] status_q;

    assign setup  = i_apb.psel & ~i_apb.penable;
    assign access = i_apb.psel & i_apb.penable;

    // Offset decode; info words and STATUS are read-only
    always_comb begin
        rd_word = 32'h0;
        err     = 1'b0;
        case (i_apb.paddr[7:0])
            proxy_test_pkg::OFS_PRE: begin
                rd_word = proxy_test_pkg::INFO_PRE;
                err     = i_apb.pwrite;
            end
            proxy_test_pkg::OFS_POST: begin
                rd_word = proxy_test_pkg::INFO_POST;
                err     = i_apb.pwrite;
            end
            proxy_test_pkg::OFS_TRIGGER: rd_word = trigger_q;
            proxy_test_pkg::OFS_STATUS: begin
                rd_word = status_q;
                err     = i_apb.pwrite;
            end
            default: err = 1'b1;
        endcase
    end

    // ------------------------------------------------
    // Response and register updates
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
            trigger_q <= 32'h0;
            status_q  <= 32'h0;
        end else begin
            pready_q  <= setup;
            pslverr_q <= setup & err;
            // Completed TRIGGER write is mirrored into STATUS
            if (access && i_apb.pwrite && !pslverr_q &&
                i_apb.paddr[7:0] == proxy_test_pkg::OFS_TRIGGER) begin
                trigger_q <= i_apb.pwdata;
                status_q  <= i_apb.pwdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (setup) begin
            prdata_q <= rd_word;
        end
    end

    assign o_apb = '{pready: pready_q, prdata: prdata_q, pslverr: pslverr_q};

endmodule

`default_nettype wire

/* src/apb_decoder.sv */
`default_nettype none

module apb_decoder (
    input  wire logic                    clk,
    input  wire logic                    srst,
    input  wire proxy_test_pkg::apb_req_t i_apb,
    output proxy_test_pkg::apb_rsp_t     o_apb,
    output proxy_test_pkg::apb_req_t     o_info_req,
    input  wire proxy_test_pkg::apb_rsp_t i_info_rsp,
    output proxy_test_pkg::apb_req_t     o_mem_req,
    input  wire proxy_test_pkg::apb_rsp_t i_mem_rsp
);
    logic [3:0] region;
    logic       hit_info;
    logic       hit_mem;
    logic       err_q;

    assign region   = i_apb.paddr[11:8];
    assign hit_info = (region == proxy_test_pkg::REGION_INFO);
    assign hit_mem  = (region == proxy_test_pkg::REGION_MEM);

    // Requests fan out with psel qualified by region
    always_comb begin
        o_info_req      = i_apb;
        o_info_req.psel = i_apb.psel & hit_info;
        o_mem_req       = i_apb;
        o_mem_req.psel  = i_apb.psel & hit_mem;
    end

    // ------------------------------------------------
    // Unmapped region completion
    // ------------------------------------------------
    // Flagged in setup so the error lands in the first access cycle
    always_ff @(posedge clk) begin
        if (srst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= i_apb.psel & ~i_apb.penable & ~hit_info & ~hit_mem;
        end
    end

    // Response return
    always_comb begin
        if (hit_info) begin
            o_apb = i_info_rsp;
        end else if (hit_mem) begin
            o_apb = i_mem_rsp;
        end else begin
            o_apb = '{pready: err_q, prdata: 32'h0, pslverr: err_q};
        end
    end

endmodule

`default_nettype wire

/* src/proxy_test_top.sv */
`default_nettype none

module proxy_test_top #(
    parameter int MEM_DEPTH = 1024
) (
    input  wire logic                    clk,
    input  wire logic                    srst,
    input  wire proxy_test_pkg::apb_req_t i_apb,
    output proxy_test_pkg::apb_rsp_t     o_apb
);
    proxy_test_pkg::apb_req_t info_req;
    proxy_test_pkg::apb_rsp_t info_rsp;
    proxy_test_pkg::apb_req_t mem_req;
    proxy_test_pkg::apb_rsp_t mem_rsp;
    proxy_test_pkg::mem_cmd_t mem_cmd;
    proxy_test_pkg::mem_sts_t mem_sts;

    logic                                  ram_en;
    logic                                  ram_wr;
    logic [proxy_test_pkg::MEM_ADDR_W-1:0] ram_addr;
    logic [31:0]                           ram_wdata;
    logic [31:0]                           ram_rdata;

    // ------------------------------------------------
    // APB decode
    // ------------------------------------------------
    apb_decoder i_apb_decoder (
        .clk        (clk),
        .srst       (srst),
        .i_apb      (i_apb),
        .o_apb      (o_apb),
        .o_info_req (info_req),
        .i_info_rsp (info_rsp),
        .o_mem_req  (mem_req),
        .i_mem_rsp  (mem_rsp)
    );

    // Register proxy
    proxy_info_regs i_proxy_info_regs (
        .clk   (clk),
        .srst  (srst),
        .i_apb (info_req),
        .o_apb (info_rsp)
    );

    // ------------------------------------------------
    // Memory proxy
    // ------------------------------------------------
    mem_proxy_regs i_mem_proxy_regs (
        .clk   (clk),
        .srst  (srst),
        .i_apb (mem_req),
        .o_apb (mem_rsp),
        .o_cmd (mem_cmd),
        .i_sts (mem_sts)
    );

    mem_proxy_engine #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_mem_proxy_engine (
        .clk         (clk),
        .srst        (srst),
        .i_cmd       (mem_cmd),
        .o_sts       (mem_sts),
        .o_ram_en    (ram_en),
        .o_ram_wr    (ram_wr),
        .o_ram_addr  (ram_addr),
        .o_ram_wdata (ram_wdata),
        .i_ram_rdata (ram_rdata)
    );

    mem_ram_sp #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_mem_ram_sp (
        .clk     (clk),
        .i_en    (ram_en),
        .i_wr    (ram_wr),
        .i_addr  (ram_addr),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 20
) (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

/* dv/proxy_test_checker.sv */
`default_nettype none

module proxy_test_checker (
    input wire logic                     clk,
    input wire logic                     srst,
    input wire proxy_test_pkg::apb_req_t i_apb_req,
    input wire proxy_test_pkg::apb_rsp_t i_apb_rsp
);
    // ------------------------------------------------
    // APB response rules
    // ------------------------------------------------
    a_ready_in_access : assert property (@(posedge clk) disable iff (srst)
        i_apb_rsp.pready |-> (i_apb_req.psel && i_apb_req.penable))
        else $error("pready high outside an APB access phase");

    a_err_with_ready : assert property (@(posedge clk) disable iff (srst)
        i_apb_rsp.pslverr |-> i_apb_rsp.pready)
        else $error("pslverr high without pready");

    // Registers have seen one reset edge by the second cycle
    a_ready_in_reset : assert property (@(posedge clk)
        (srst && $past(srst)) |-> !i_apb_rsp.pready)
        else $error("pready high during reset");

endmodule

bind proxy_test_top proxy_test_checker i_checker (
    .clk       (clk),
    .srst      (srst),
    .i_apb_req (i_apb),
    .i_apb_rsp (o_apb)
);

`default_nettype wire

/* dv/proxy_test_tb.sv */
`default_nettype none

module proxy_test_tb;
    localparam int         MEM_DEPTH = 1024;
    localparam int         MAX_ROWS  = 192;
    localparam int         ACC_LIMIT = 16;
    localparam logic [3:0] INFO      = proxy_test_pkg::REGION_INFO;
    localparam logic [3:0] MEM       = proxy_test_pkg::REGION_MEM;

    // One APB access per row
    typedef struct packed {
        logic        wr;
        logic        poll;
        logic [3:0]  region;
        logic [7:0]  offset;
        logic [31:0] wdata;
        logic        exp_err;
        logic        use_model;
        logic [31:0] exp_rdata;
    } row_t;

    logic                     clk;
    logic                     srst;
    proxy_test_pkg::apb_req_t apb_req;
    proxy_test_pkg::apb_rsp_t apb_rsp;

    row_t        rows [MAX_ROWS];
    int          n_rows;
    integer      seed;
    logic [31:0] mem_model [MEM_DEPTH];
    logic [15:0] addr_shadow;
    logic [31:0] wdata_shadow;
    logic [31:0] rd_shadow;
    logic [31:0] trig_shadow;
    logic [15:0] written_addrs [$];

    tb_clk_gen #(.PERIOD(20)) i_clk_gen (.o_clk(clk));

    proxy_test_top #(
        .MEM_DEPTH (MEM_DEPTH)
    ) i_dut (
        .clk   (clk),
        .srst  (srst),
        .i_apb (apb_req),
        .o_apb (apb_rsp)
    );

    // ------------------------------------------------
    // Failure handling
    // ------------------------------------------------
    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic show_mismatch(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic handle_timeout(input string msg);
        $display("Timeout at time %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_rsp(input proxy_test_pkg::apb_rsp_t got,
                             input proxy_test_pkg::apb_rsp_t exp,
                             input logic with_data, input int row);
        if (got.pslverr !== exp.pslverr) begin
            show_mismatch($sformatf("row %0d: pslverr %0b, expected %0b",
                                    row, got.pslverr, exp.pslverr));
        end else if (with_data && got.prdata !== exp.prdata) begin
            show_mismatch($sformatf("row %0d: prdata 0x%08h, expected 0x%08h",
                                    row, got.prdata, exp.prdata));
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input int row);
        if (got !== exp) begin
            show_mismatch($sformatf("row %0d: read word 0x%08h, model 0x%08h",
                                    row, got, exp));
        end
    endtask

    // ------------------------------------------------
    // APB master
    // ------------------------------------------------
    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input logic [31:0] wdata,
                              output proxy_test_pkg::apb_rsp_t rsp);
        int waited;
        waited = 0;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            waited++;
            if (waited > ACC_LIMIT) begin
                handle_timeout("APB access got no pready");
            end else begin
                @(negedge clk);
            end
        end
        rsp = apb_rsp;
        @(posedge clk);
        apb_req <= '0;
    endtask

    // Poll the busy bit until the memory proxy is idle
    task automatic wait_mem_idle();
        proxy_test_pkg::apb_rsp_t rsp;
        int                       polls;
        polls = 0;
        apb_access(1'b0, {MEM, proxy_test_pkg::OFS_MEM_STATUS}, 32'h0, rsp);
        while (rsp.prdata[0]) begin
            polls++;
            if (polls > MEM_DEPTH) begin
                handle_timeout("memory proxy stayed busy");
            end else begin
                apb_access(1'b0, {MEM, proxy_test_pkg::OFS_MEM_STATUS}, 32'h0, rsp);
            end
        end
    endtask

    // ------------------------------------------------
    // Reference model
    // ------------------------------------------------
    function automatic logic [31:0] expected_read(input logic [3:0] region,
                                                  input logic [7:0] offset);
        logic [31:0] word;
        word = 32'h0;
        if (region == INFO) begin
            if (offset == proxy_test_pkg::OFS_TRIGGER ||
                offset == proxy_test_pkg::OFS_STATUS) begin
                word = trig_shadow;
            end
        end else if (region == MEM) begin
            case (offset)
                proxy_test_pkg::OFS_ADDR:    word = {16'h0, addr_shadow};
                proxy_test_pkg::OFS_WR_DATA: word = wdata_shadow;
                proxy_test_pkg::OFS_RD_DATA: word = rd_shadow;
                default:                     word = 32'h0;
            endcase
        end
        return word;
    endfunction

    task automatic update_model(input row_t row);
        int idx;
        idx = int'(addr_shadow) % MEM_DEPTH;
        if (row.region == INFO && row.offset == proxy_test_pkg::OFS_TRIGGER) begin
            trig_shadow = row.wdata;
        end else if (row.region == MEM) begin
            case (row.offset)
                proxy_test_pkg::OFS_ADDR:    addr_shadow = row.wdata[15:0];
                proxy_test_pkg::OFS_WR_DATA: wdata_shadow = row.wdata;
                proxy_test_pkg::OFS_CMD: begin
                    case (row.wdata[1:0])
                        proxy_test_pkg::OP_WRITE: mem_model[idx] = wdata_shadow;
                        proxy_test_pkg::OP_READ:  rd_shadow = mem_model[idx];
                        proxy_test_pkg::OP_CLEAR: begin
                            for (int a = 0; a < MEM_DEPTH; a++) begin
                                mem_model[a] = 32'h0;
                            end
                        end
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    endtask

    // ------------------------------------------------
    // Stimulus table
    // ------------------------------------------------
    task automatic add_row(input logic wr, input logic poll, input logic [3:0] region,
                           input logic [7:0] offset, input logic [31:0] wdata,
                           input logic exp_err, input logic use_model,
                           input logic [31:0] exp_rdata);
        rows[n_rows] = '{wr: wr, poll: poll, region: region, offset: offset,
                         wdata: wdata, exp_err: exp_err, use_model: use_model,
                         exp_rdata: exp_rdata};
        n_rows++;
    endtask

    task automatic add_mem_write(input logic [15:0] addr, input logic [31:0] data);
        add_row(1'b1, 1'b0, MEM, proxy_test_pkg::OFS_ADDR, {16'h0, addr}, 1'b0, 1'b0, 32'h0);
        add_row(1'b1, 1'b0, MEM, proxy_test_pkg::OFS_WR_DATA, data, 1'b0, 1'b0, 32'h0);
        add_row(1'b1, 1'b1, MEM, proxy_test_pkg::OFS_CMD,
                32'(proxy_test_pkg::OP_WRITE), 1'b0, 1'b0, 32'h0);
    endtask

    task automatic add_mem_read(input logic [15:0] addr);
        add_row(1'b1, 1'b0, MEM, proxy_test_pkg::OFS_ADDR, {16'h0, addr}, 1'b0, 1'b0, 32'h0);
        add_row(1'b1, 1'b1, MEM, proxy_test_pkg::OFS_CMD,
                32'(proxy_test_pkg::OP_READ), 1'b0, 1'b0, 32'h0);
        add_row(1'b0, 1'b1, MEM, proxy_test_pkg::OFS_RD_DATA, 32'h0, 1'b0, 1'b1, 32'h0);
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [15:0] addr;
        n_rows = 0;
        // Information words and reset values
        add_row(1'b0, 1'b0, INFO, proxy_test_pkg::OFS_PRE, 32'h0, 1'b0, 1'b0, 32'h2050_5245);
        add_row(1'b0, 1'b0, INFO, proxy_test_pkg::OFS_POST, 32'h0, 1'b0, 1'b0, 32'h504F_5354);
        add_row(1'b0, 1'b0, INFO, proxy_test_pkg::OFS_STATUS, 32'h0, 1'b0, 1'b1, 32'h0);
        add_row(1'b0, 1'b0, INFO, proxy_test_pkg::OFS_TRIGGER, 32'h0, 1'b0, 1'b1, 32'h0);
        // Trigger capture
        add_row(1'b1, 1'b0, INFO, proxy_test_pkg::OFS_TRIGGER, 32'hC0DE_1234, 1'b0, 1'b0, 32'h0);
        add_row(1'b0, 1'b0, INFO, proxy_test_pkg::OFS_STATUS, 32'h0, 1'b0, 1'b1, 32'h0);
        add_row(1'b0, 1'b0, INFO, proxy_test_pkg::OFS_TRIGGER, 32'h0, 1'b0, 1'b1, 32'h0);
        add_row(1'b0, 1'b0, INFO, proxy_test_pkg::OFS_STATUS, 32'h0, 1'b0, 1'b1, 32'h0);
        // Illegal accesses
        add_row(1'b1, 1'b0, INFO, proxy_test_pkg::OFS_PRE, 32'hFFFF_FFFF, 1'b1, 1'b0, 32'h0);
        add_row(1'b1, 1'b0, INFO, proxy_test_pkg::OFS_POST, 32'h1111_1111, 1'b1, 1'b0, 32'h0);
        add_row(1'b1, 1'b0, INFO, proxy_test_pkg::OFS_STATUS, 32'h0BAD_0BAD, 1'b1, 1'b0, 32'h0);
        add_row(1'b0, 1'b0, INFO, 8'h10, 32'h0, 1'b1, 1'b0, 32'h0);
        add_row(1'b1, 1'b0, INFO, 8'h14, 32'h5A5A_5A5A, 1'b1, 1'b0, 32'h0);
        add_row(1'b0, 1'b0, 4'h2, 8'h00, 32'h0, 1'b1, 1'b0, 32'h0);
        add_row(1'b1, 1'b0, 4'hF, 8'h08, 32'h7777_7777, 1'b1, 1'b0, 32'h0);
        add_row(1'b0, 1'b0, INFO, proxy_test_pkg::OFS_PRE, 32'h0, 1'b0, 1'b0, 32'h2050_5245);
        add_row(1'b0, 1'b0, INFO, proxy_test_pkg::OFS_POST, 32'h0, 1'b0, 1'b0, 32'h504F_5354);
        add_row(1'b0, 1'b0, INFO, proxy_test_pkg::OFS_STATUS, 32'h0, 1'b0, 1'b1, 32'h0);
        add_row(1'b0, 1'b0, INFO, proxy_test_pkg::OFS_TRIGGER, 32'h0, 1'b0, 1'b1, 32'h0);

        // RAM is clear once the reset walk ends
        add_row(1'b0, 1'b1, MEM, proxy_test_pkg::OFS_MEM_STATUS, 32'h0, 1'b0, 1'b1, 32'h0);
        add_mem_read(16'd0);
        add_mem_read(16'd1);
        add_mem_read(16'd511);
        add_mem_read(16'(MEM_DEPTH - 1));

        // Random writes, plus one address above the depth that aliases
        for (int i = 0; i < 6; i++) begin
            r    = $random(seed);
            addr = r[15:0] & 16'(MEM_DEPTH - 1);
            add_mem_write(addr, $random(seed));
            written_addrs.push_back(addr);
        end
        add_mem_write(16'h0403, $random(seed));
        written_addrs.push_back(16'h0403);
        add_row(1'b0, 1'b0, MEM, proxy_test_pkg::OFS_ADDR, 32'h0, 1'b0, 1'b1, 32'h0);
        add_row(1'b0, 1'b0, MEM, proxy_test_pkg::OFS_WR_DATA, 32'h0, 1'b0, 1'b1, 32'h0);
        foreach (written_addrs[i]) begin
            add_mem_read(written_addrs[i]);
        end
        add_mem_read(16'd3);
        add_row(1'b1, 1'b0, MEM, proxy_test_pkg::OFS_MEM_STATUS, 32'h1, 1'b1, 1'b0, 32'h0);
        add_row(1'b1, 1'b0, MEM, proxy_test_pkg::OFS_RD_DATA, 32'h1, 1'b1, 1'b0, 32'h0);
        add_row(1'b0, 1'b0, MEM, proxy_test_pkg::OFS_RD_DATA, 32'h0, 1'b0, 1'b1, 32'h0);
        add_row(1'b0, 1'b0, MEM, 8'h20, 32'h0, 1'b1, 1'b0, 32'h0);

        // Clear, then a command while the clear runs
        add_row(1'b1, 1'b1, MEM, proxy_test_pkg::OFS_CMD,
                32'(proxy_test_pkg::OP_CLEAR), 1'b0, 1'b0, 32'h0);
        add_row(1'b1, 1'b0, MEM, proxy_test_pkg::OFS_CMD,
                32'(proxy_test_pkg::OP_READ), 1'b1, 1'b0, 32'h0);
        foreach (written_addrs[i]) begin
            add_mem_read(written_addrs[i]);
        end
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------
    initial begin
        proxy_test_pkg::apb_rsp_t rsp;
        proxy_test_pkg::apb_rsp_t exp;
        row_t                     row;
        seed         = 32'h1c05_7091;
        apb_req      = '0;
        srst         = 1'b1;
        addr_shadow  = 16'h0;
        wdata_shadow = 32'h0;
        rd_shadow    = 32'h0;
        trig_shadow  = 32'h0;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            mem_model[a] = 32'h0;
        end
        build_table();

        repeat (5) @(posedge clk);
        srst <= 1'b0;

        for (int i = 0; i < n_rows; i++) begin
            row = rows[i];
            if (row.poll) begin
                wait_mem_idle();
            end
            apb_access(row.wr, {row.region, row.offset}, row.wdata, rsp);
            exp = '{pready: 1'b1, prdata: row.exp_rdata, pslverr: row.exp_err};
            if (row.use_model) begin
                check_rsp(rsp, exp, 1'b0, i);
                check_word(rsp.prdata, expected_read(row.region, row.offset), i);
            end else begin
                check_rsp(rsp, exp, !row.wr && !row.exp_err, i);
            end
            if (row.wr && !row.exp_err) begin
                update_model(row);
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
src/proxy_test_pkg.sv
src/mem_ram_sp.sv
src/mem_proxy_engine.sv
src/mem_proxy_regs.sv
src/proxy_info_regs.sv
src/apb_decoder.sv
src/proxy_test_top.sv
dv/tb_clk_gen.sv
dv/proxy_test_checker.sv
dv/proxy_test_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module proxy_test_tb \
    -Mdir obj_dir \
    -f compile.f

./obj_dir/Vproxy_test_tb
